// File: hw/ide_bridge.sv
`timescale 1ns/10ps
`default_nettype none

`include "zports_config.svh"

module ide_bridge
	import zports_bus_pkg::*;
(
	input  logic      zclk,
	input  logic      rst_n,
	input  zaddr_t    a,
	input  zbyte_t    din,
	input  logic      iorq_n,
	input  logic      rd_n,
	input  logic      wr_n,
	input  logic      port_wr,
	input  logic      port_rd,
	input  logic      ide_sel,      // physical ide port addressed
	input  ide_word_t idein,
	output ide_word_t ideout,
	output logic      idedataout,   // low while the drive puts data out
	output logic [2:0] ide_a,
	output logic      ide_cs0_n,
	output logic      ide_cs1_n,
	output logic      ide_rd_n,
	output logic      ide_wr_n,
	output zbyte_t    ide_rd_data
);

	logic      is_10;
	logic      is_11;
	logic      ide_acc;     // any ide access strobe
	logic      lo_rd;       // low byte read, catch the high byte
	logic      rd_trig;     // divide read trigger
	logic      wrlo_trig;   // divide write trigger
	logic      wrhi_trig;   // normal write trigger
	logic      rd_hold;     // trigger frozen for the bus cycle
	logic      wrlo_hold;
	logic      wrhi_hold;
	ide_word_t wr_word;     // pre-written half of the word
	zbyte_t    hi_in;       // high byte kept from the drive

	assign is_10   = (a[7:0] == `ZP_NIDE10);
	assign is_11   = (a[7:0] == `ZP_NIDE11);
	assign ide_acc = (ide_sel || is_11) && (port_rd || port_wr);
	assign lo_rd   = port_rd && is_10 && !rd_trig;

	////////////////////////////////////////////////////////////
	// nemo / divide triggers
	////////////////////////////////////////////////////////////

	// normal rd #10 #11   divide rd #10 #10
	// normal wr #11 #10   divide wr #10 #10
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_trig   <= 1'b0;
			wrlo_trig <= 1'b0;
			wrhi_trig <= 1'b0;
		end
		else
		begin
			if (lo_rd)
				rd_trig <= 1'b1;           // next #10 read gives the high byte
			else if (ide_acc)
				rd_trig <= 1'b0;
			if (ide_acc)
			begin
				wrhi_trig <= is_11 && port_wr;
				wrlo_trig <= is_10 && port_wr && !wrhi_trig && !wrlo_trig;
			end
		end
	end

	// copies only follow between bus cycles
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_hold   <= 1'b0;
			wrlo_hold <= 1'b0;
			wrhi_hold <= 1'b0;
		end
		else
		begin
			if (rd_n)
				rd_hold <= rd_trig;
			if (wr_n)
			begin
				wrlo_hold <= wrlo_trig;
				wrhi_hold <= wrhi_trig;
			end
		end
	end

	always_ff @(posedge zclk)
	begin
		if (port_wr && is_11)
			wr_word[15:8] <= din;
		if (port_wr && is_10 && !wrlo_trig)
			wr_word[7:0] <= din;           // divide low byte, no drive cycle
		if (lo_rd)
			hi_in <= idein[15:8];
	end

	////////////////////////////////////////////////////////////
	// drive side
	////////////////////////////////////////////////////////////

	assign ide_a     = a[7:5];
	assign ide_cs0_n = ~(ide_sel && (a[7:0] != `ZP_NIDE_C8));
	assign ide_cs1_n = ~(ide_sel && (a[7:0] == `ZP_NIDE_C8));   // control block

	// second divide read is served from hi_in
	assign ide_rd_n = iorq_n | rd_n | ~ide_sel | (rd_hold & is_10);
	// first divide write only fills wr_word
	assign ide_wr_n = iorq_n | wr_n | ~ide_sel | (is_10 & ~wrlo_hold & ~wrhi_hold);
	assign idedataout = ide_rd_n;

	assign ideout[15:8] = wrhi_hold ? wr_word[15:8] : din;
	assign ideout[7:0]  = wrlo_hold ? wr_word[7:0] : din;

	always_comb
	begin
		if (is_11 || (rd_hold && is_10))
			ide_rd_data = hi_in;
		else
			ide_rd_data = idein[7:0];
	end

endmodule

`default_nettype wire

// File: hw/io_strobe_gen.sv
`timescale 1ns/10ps
`default_nettype none

module io_strobe_gen
(
	input  logic zclk,
	input  logic rst_n,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	output logic port_wr,   // one clock per io write
	output logic port_rd    // one clock per io read
);

	logic wr_cyc_s;   // io write seen
	logic wr_cyc_d;
	logic rd_cyc_s;   // io read seen
	logic rd_cyc_d;

	// sample the bus, then strobe on the rising edge of the sampled flag
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_cyc_s <= 1'b0;
			wr_cyc_d <= 1'b0;
			rd_cyc_s <= 1'b0;
			rd_cyc_d <= 1'b0;
			port_wr  <= 1'b0;
			port_rd  <= 1'b0;
		end
		else
		begin
			wr_cyc_s <= ~(iorq_n | wr_n);
			rd_cyc_s <= ~(iorq_n | rd_n);
			wr_cyc_d <= wr_cyc_s;
			rd_cyc_d <= rd_cyc_s;
			port_wr  <= wr_cyc_s & ~wr_cyc_d;   // no repeat till cycle ends
			port_rd  <= rd_cyc_s & ~rd_cyc_d;
		end
	end

endmodule

`default_nettype wire

// File: hw/mem_paging.sv
`timescale 1ns/10ps
`default_nettype none

`include "zports_config.svh"

module mem_paging
	import zports_bus_pkg::*;
	import zports_regs_pkg::*;
(
	input  logic      zclk,
	input  logic      rst_n,
	input  zaddr_t    a,
	input  zbyte_t    din,
	input  logic [1:0] rstrom,   // rom choice at reset
	input  logic      fd_wr,
	input  logic      f7_wr,
	output page_reg_t p7ffd,
	output page_reg_t peff7
);

	logic      rst_s1;     // reset sync stages
	logic      rst_s2;
	page_reg_t p7ffd_r;
	page_reg_t peff7_r;
	logic      rom_bit;    // 7ffd bit 4
	logic      lock;       // 1mb off
	logic      fd_ok;

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rst_s1 <= 1'b1;
			rst_s2 <= 1'b1;
		end
		else
		begin
			rst_s1 <= 1'b0;
			rst_s2 <= rst_s1;   // two clocks after release
		end
	end

	assign lock  = peff7_r[2];
	assign fd_ok = fd_wr && !a[15] && !(p7ffd_r[5] && lock);   // 48k lock

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_r <= `ZP_PAGE_RST;
			peff7_r <= `ZP_PAGE_RST;
		end
		else
		begin
			if (fd_ok)
				p7ffd_r <= din;   // page, screen, rom, lock
			if (f7_wr && !a[12])
				peff7_r <= din;
		end
	end

	// rom select loaded from outside while reset settles
	always_ff @(posedge zclk)
	begin
		if (rst_s2)
			rom_bit <= rstrom[0];
		else if (fd_ok)
			rom_bit <= din[4];
	end

	assign p7ffd = lock ? {3'b000, rom_bit, p7ffd_r[3:0]} :
	                      {p7ffd_r[7:5], rom_bit, p7ffd_r[3:0]};
	assign peff7 = lock ? {peff7_r[7], 1'b0, peff7_r[5:4], 3'b000, peff7_r[0]} : peff7_r;

endmodule

`default_nettype wire

// File: hw/port_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "zports_config.svh"

module port_decode
	import zports_bus_pkg::*;
(
	input  zaddr_t     a,
	input  logic       dos,         // shadow mode
	input  logic       iorq_n,
	input  logic       rd_n,
	input  logic       port_wr,
	input  logic       port_rd,
	input  logic [4:0] keys_in,
	input  logic       tape_read,
	input  logic [4:0] kj_in,
	input  zbyte_t     mus_in,
	input  zbyte_t     ide_rd_data,
	output logic       porthit,
	output logic       dataout,
	output zbyte_t     dout,
	output logic       ide_sel,
	output logic       fe_wr,
	output logic       fd_wr,
	output logic       f7_wr,
	output logic       cv_wr,
	output logic       sd_wr,
	output logic       xt_addr_wr,
	output logic       xt_data_wr
);

	zbyte_t loa;      // port number
	logic   ide_any;  // physical ide ports plus #11
	logic   sd_hit;
	logic   cv_hit;
	logic   xt_hit;
	logic   rd_cyc;

	assign loa = a[7:0];

	// even ide ports 10,30..f0 share the low five bits
	assign ide_sel = ((loa & 8'h1F) == `ZP_NIDE10) || (loa == `ZP_NIDE_C8);
	assign ide_any = ide_sel || (loa == `ZP_NIDE11);

	assign sd_hit = (loa == `ZP_SD0) || (loa == `ZP_SD1) ||
	                (loa == `ZP_SD2) || (loa == `ZP_SD3);
	assign cv_hit = (loa == `ZP_CVX1) || (loa == `ZP_CVX2);
	assign xt_hit = (a == `ZP_XT_ADDR) || (a == `ZP_XT_DATA);

	////////////////////////////////////////////////////////////
	// hit and read side
	////////////////////////////////////////////////////////////

	always_comb
	begin
		porthit = (loa == `ZP_PORT_FE) || (loa == `ZP_PORT_FD) || ide_any ||
		          (loa == `ZP_KMOUSE) || cv_hit || xt_hit;
		if (!dos) // joystick, eff7 and soundrive hidden in shadow
			porthit = porthit || (loa == `ZP_KJOY) || (loa == `ZP_PORT_F7) || sd_hit;
	end

	assign rd_cyc  = ~iorq_n & ~rd_n;
	assign dataout = porthit & (rd_cyc | port_rd);   // held through the strobe edge

	always_comb
	begin
		if (loa == `ZP_PORT_FE)
			dout = {1'b1, tape_read, 1'b0, keys_in};
		else if (ide_any)
			dout = ide_rd_data;    // even or odd byte from the bridge
		else if (loa == `ZP_KJOY)
			dout = {3'b000, kj_in};
		else if (loa == `ZP_KMOUSE)
			dout = mus_in;
		else
			dout = `ZP_OPEN_BUS;
	end

	////////////////////////////////////////////////////////////
	// write strobes
	////////////////////////////////////////////////////////////

	assign fe_wr      = port_wr && (loa == `ZP_PORT_FE);
	assign fd_wr      = port_wr && (loa == `ZP_PORT_FD);    // a15 checked in paging
	assign f7_wr      = port_wr && (loa == `ZP_PORT_F7) && !dos;
	assign cv_wr      = port_wr && cv_hit;
	assign sd_wr      = port_wr && sd_hit && !dos;
	assign xt_addr_wr = port_wr && (a == `ZP_XT_ADDR);
	assign xt_data_wr = port_wr && (a == `ZP_XT_DATA);

endmodule

`default_nettype wire

// File: hw/sound_border.sv
`timescale 1ns/10ps
`default_nettype none

`include "zports_config.svh"

module sound_border
	import zports_bus_pkg::*;
	import zports_regs_pkg::*;
(
	input  logic    zclk,
	input  logic    rst_n,
	input  zaddr_t  a,
	input  zbyte_t  din,
	input  logic    fe_wr,
	input  logic    cv_wr,
	input  logic    sd_wr,
	input  logic    xt_addr_wr,
	input  logic    xt_data_wr,
	output border_t border,
	output sample_t psd0,
	output sample_t psd1,
	output sample_t psd2,
	output sample_t psd3,
	output zbyte_t  vcfg,
	output zbyte_t  sp_wa,     // palette address
	output logic    sp_we,
	output zbyte_t  sf_wa,     // sprite file address
	output logic    sf_we
);

	xt_reg_t xt_idx;   // extended register index

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border <= '0;
			psd0   <= '0;
			psd1   <= '0;
			psd2   <= '0;
			psd3   <= '0;
			vcfg   <= '0;
			xt_idx <= XBorder;
		end
		else
		begin
			if (xt_addr_wr)
				xt_idx <= xt_reg_t'(din);
			if (fe_wr) // beeper on 0..1, tape out on 3
			begin
				psd0   <= {8{din[4]}};
				psd1   <= {8{din[4]}};
				psd2   <= {din[4], {7{din[3]}}};
				psd3   <= {8{din[3]}};
				border <= {din[1], 1'b0, din[2], 1'b0, din[0], 1'b0};   // grb in high bits
			end
			if (cv_wr) // covox drives every channel
			begin
				psd0 <= din;
				psd1 <= din;
				psd2 <= din;
				psd3 <= din;
			end
			if (sd_wr)
			begin
				case (a[7:0])
					`ZP_SD0: psd0 <= din;
					`ZP_SD1: psd1 <= din;
					`ZP_SD2: psd2 <= din;
					`ZP_SD3: psd3 <= din;
					default: ;
				endcase
			end
			if (xt_data_wr)
			begin
				case (xt_idx)
					XBorder: border <= din[`ZP_BORDER_W-1:0];
					VConfig: vcfg   <= din;
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// palette and sprite file address
	////////////////////////////////////////////////////////////

	always_ff @(posedge zclk)
	begin
		if (xt_data_wr && (xt_idx == PalAddr))
			sp_wa <= din;
		if (xt_data_wr && (xt_idx == SFAddr))
			sf_wa <= din;
	end

	assign sp_we = xt_data_wr && (xt_idx == PalData);   // data itself is din
	assign sf_we = xt_data_wr && (xt_idx == SFData);

endmodule

`default_nettype wire

// File: hw/zports.sv
`timescale 1ns/10ps
`default_nettype none

module zports
	import zports_bus_pkg::*;
	import zports_regs_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  zaddr_t     a,
	input  zbyte_t     din,
	output zbyte_t     dout,
	output logic       dataout,     // cpu reads from us
	input  logic       iorq_n,
	input  logic       rd_n,
	input  logic       wr_n,
	output logic       porthit,     // steers the external iorq
	output ide_word_t  ideout,
	input  ide_word_t  idein,
	output logic       idedataout,
	output logic [2:0] ide_a,
	output logic       ide_cs0_n,
	output logic       ide_cs1_n,
	output logic       ide_rd_n,
	output logic       ide_wr_n,
	input  logic [4:0] keys_in,
	input  zbyte_t     mus_in,
	input  logic [4:0] kj_in,
	input  logic       tape_read,
	input  logic       dos,
	input  logic [1:0] rstrom,
	output border_t    border,
	output sample_t    psd0,
	output sample_t    psd1,
	output sample_t    psd2,
	output sample_t    psd3,
	output page_reg_t  p7ffd,
	output page_reg_t  peff7,
	output zbyte_t     vcfg,
	output zbyte_t     sp_wa,
	output logic       sp_we,
	output zbyte_t     sf_wa,
	output logic       sf_we
);

	logic   port_wr;
	logic   port_rd;
	logic   ide_sel;
	zbyte_t ide_rd_data;
	logic   fe_wr;
	logic   fd_wr;
	logic   f7_wr;
	logic   cv_wr;
	logic   sd_wr;
	logic   xt_addr_wr;
	logic   xt_data_wr;

	io_strobe_gen u_strobe
	(
		.zclk    (zclk),
		.rst_n   (rst_n),
		.iorq_n  (iorq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.port_wr (port_wr),
		.port_rd (port_rd)
	);

	port_decode u_decode
	(
		.a           (a),
		.dos         (dos),
		.iorq_n      (iorq_n),
		.rd_n        (rd_n),
		.port_wr     (port_wr),
		.port_rd     (port_rd),
		.keys_in     (keys_in),
		.tape_read   (tape_read),
		.kj_in       (kj_in),
		.mus_in      (mus_in),
		.ide_rd_data (ide_rd_data),
		.porthit     (porthit),
		.dataout     (dataout),
		.dout        (dout),
		.ide_sel     (ide_sel),
		.fe_wr       (fe_wr),
		.fd_wr       (fd_wr),
		.f7_wr       (f7_wr),
		.cv_wr       (cv_wr),
		.sd_wr       (sd_wr),
		.xt_addr_wr  (xt_addr_wr),
		.xt_data_wr  (xt_data_wr)
	);

	ide_bridge u_ide
	(
		.zclk        (zclk),
		.rst_n       (rst_n),
		.a           (a),
		.din         (din),
		.iorq_n      (iorq_n),
		.rd_n        (rd_n),
		.wr_n        (wr_n),
		.port_wr     (port_wr),
		.port_rd     (port_rd),
		.ide_sel     (ide_sel),
		.idein       (idein),
		.ideout      (ideout),
		.idedataout  (idedataout),
		.ide_a       (ide_a),
		.ide_cs0_n   (ide_cs0_n),
		.ide_cs1_n   (ide_cs1_n),
		.ide_rd_n    (ide_rd_n),
		.ide_wr_n    (ide_wr_n),
		.ide_rd_data (ide_rd_data)
	);

	mem_paging u_paging
	(
		.zclk   (zclk),
		.rst_n  (rst_n),
		.a      (a),
		.din    (din),
		.rstrom (rstrom),
		.fd_wr  (fd_wr),
		.f7_wr  (f7_wr),
		.p7ffd  (p7ffd),
		.peff7  (peff7)
	);

	sound_border u_sound
	(
		.zclk       (zclk),
		.rst_n      (rst_n),
		.a          (a),
		.din        (din),
		.fe_wr      (fe_wr),
		.cv_wr      (cv_wr),
		.sd_wr      (sd_wr),
		.xt_addr_wr (xt_addr_wr),
		.xt_data_wr (xt_data_wr),
		.border     (border),
		.psd0       (psd0),
		.psd1       (psd1),
		.psd2       (psd2),
		.psd3       (psd3),
		.vcfg       (vcfg),
		.sp_wa      (sp_wa),
		.sp_we      (sp_we),
		.sf_wa      (sf_wa),
		.sf_we      (sf_we)
	);

endmodule

`default_nettype wire

// File: hw/zports_bus_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////
// z80 bus side types
////////////////////////////////////////////////////////////

package zports_bus_pkg;

	// data bus byte
	typedef logic [7:0] zbyte_t;

	// full cpu address, port number in the low byte
	typedef logic [15:0] zaddr_t;

	// ide data bus
	// high byte is latched or pre-written, low byte goes straight through
	typedef logic [15:0] ide_word_t;

endpackage

`default_nettype wire

// File: hw/zports_config.svh
`ifndef ZPORTS_CONFIG_SVH
`define ZPORTS_CONFIG_SVH

// low address byte of each decoded port
`define ZP_PORT_FE   8'hFE   // border, beeper, keyboard
`define ZP_PORT_FD   8'hFD   // 7ffd paging
`define ZP_PORT_F7   8'hF7   // eff7 paging
`define ZP_NIDE10    8'h10   // ide data low, also base of the even ports
`define ZP_NIDE11    8'h11   // ide data high
`define ZP_NIDE_C8   8'hC8   // ide control block
`define ZP_KJOY      8'h1F   // kempston joystick
`define ZP_KMOUSE    8'hDF   // kempston mouse
`define ZP_SD0       8'h0F   // soundrive channels
`define ZP_SD1       8'h1F
`define ZP_SD2       8'h4F
`define ZP_SD3       8'h5F
`define ZP_CVX1      8'hFB   // covox
`define ZP_CVX2      8'hDD

// extended register pair, full address
`define ZP_XT_ADDR   16'h55FF
`define ZP_XT_DATA   16'h56FF

`define ZP_BORDER_W  6       // border colour bits
`define ZP_OPEN_BUS  8'hFF   // floating bus
`define ZP_PAGE_RST  8'h00   // paging registers after reset

`endif

// File: hw/zports_regs_pkg.sv
`default_nettype none

`include "zports_config.svh"

////////////////////////////////////////////////////////////
// internal register types
////////////////////////////////////////////////////////////

package zports_regs_pkg;

	// index written at 55ff
	typedef enum logic [7:0] {
		XBorder = 8'h00,   // border colour
		VConfig = 8'h08,   // video mode
		PalAddr = 8'h09,   // palette ram address
		PalData = 8'h0A,   // palette write pulse
		SFAddr  = 8'h0B,   // sprite file address
		SFData  = 8'h0C    // sprite file write pulse
	} xt_reg_t;

	typedef logic [7:0] sample_t;                  // one dac channel
	typedef logic [`ZP_BORDER_W-1:0] border_t;     // border colour
	typedef logic [7:0] page_reg_t;                // 7ffd / eff7

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the zports testbench, verdict taken from the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/10ps --top-module tb_zports \
	-f sources.f -Mdir obj_dir -o tb_zports \
	&& ./obj_dir/tb_zports 2>&1 | tee sim.log \
	|| { echo "build or simulation did not complete"; exit 1; }

[ -s sim.log ] || { echo "simulation log is empty"; exit 1; }
grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0

// File: sources.f
+incdir+hw
hw/zports_bus_pkg.sv
hw/zports_regs_pkg.sv
hw/io_strobe_gen.sv
hw/port_decode.sv
hw/ide_bridge.sv
hw/mem_paging.sv
hw/sound_border.sv
hw/zports.sv
verif/tb_zports.sv

// File: verif/tb_zports.sv
`timescale 1ns/10ps
`default_nettype none

`include "zports_config.svh"

module tb_zports
	import zports_bus_pkg::*;
	import zports_regs_pkg::*;
();

	localparam int STROBE_TMO = 8;   // clocks allowed before a strobe shows up

	logic       zclk;
	logic       rst_n;
	zaddr_t     a;
	zbyte_t     din;
	zbyte_t     dout;
	logic       dataout;
	logic       iorq_n;
	logic       rd_n;
	logic       wr_n;
	logic       porthit;
	ide_word_t  ideout;
	ide_word_t  idein;
	logic       idedataout;
	logic [2:0] ide_a;
	logic       ide_cs0_n;
	logic       ide_cs1_n;
	logic       ide_rd_n;
	logic       ide_wr_n;
	logic [4:0] keys_in;
	zbyte_t     mus_in;
	logic [4:0] kj_in;
	logic       tape_read;
	logic       dos;
	logic [1:0] rstrom;
	border_t    border;
	sample_t    psd0;
	sample_t    psd1;
	sample_t    psd2;
	sample_t    psd3;
	page_reg_t  p7ffd;
	page_reg_t  peff7;
	zbyte_t     vcfg;
	zbyte_t     sp_wa;
	logic       sp_we;
	zbyte_t     sf_wa;
	logic       sf_we;

	// bus-side view taken in the strobe cycle
	zbyte_t     cap_dout;
	logic       cap_dataout;
	logic       cap_porthit;
	logic       cap_rd_n;
	logic       cap_wr_n;
	ide_word_t  cap_ideout;
	logic       cap_sp_we;
	logic       cap_sf_we;
	logic       cap_cs0_n;
	logic       cap_cs1_n;
	logic [2:0] cap_ide_a;
	logic       cap_idedataout;

	integer     seed = 32'h8e98_f338;
	int         checks = 0;
	int         errors = 0;
	int         timeouts = 0;

	zports u_zports (.*);

	initial
	begin
		zclk = 1'b0;
		forever #20 zclk = ~zclk;   // 25 MHz
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	function automatic zbyte_t next_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic end_run();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	endtask

	task automatic check_byte(input string name, input zbyte_t got, input zbyte_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input ide_word_t got, input ide_word_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_border(input string name, input border_t got, input border_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_ide_a(input string name, input logic [2:0] got,
	                           input logic [2:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_samples(input sample_t e0, input sample_t e1,
	                             input sample_t e2, input sample_t e3);
		check_byte("psd0", psd0, e0);
		check_byte("psd1", psd1, e1);
		check_byte("psd2", psd2, e2);
		check_byte("psd3", psd3, e3);
	endtask

	// n clocks, leaves us 2 ns past the edge
	task automatic idle(input int n);
		int i;
		for (i = 0; i < n; i++)
		begin
			@(posedge zclk);
			#2;
		end
	endtask

	task automatic wait_strobe(input logic want_wr);
		int   n;
		logic seen;
		n = 0;
		seen = want_wr ? u_zports.port_wr : u_zports.port_rd;
		while (!seen && n < STROBE_TMO)
		begin
			@(posedge zclk);
			#2;
			n++;
			seen = want_wr ? u_zports.port_wr : u_zports.port_rd;
		end
		if (!seen)
		begin
			timeouts++;
			$display("no port %s strobe within %0d clocks", want_wr ? "write" : "read",
			         STROBE_TMO);
			end_run();
		end
	endtask

	// one io write, four clocks low, two idle after
	task automatic io_write(input zaddr_t addr, input zbyte_t data);
		a = addr;
		din = data;
		iorq_n = 1'b0;
		wr_n = 1'b0;
		wait_strobe(1'b1);
		cap_porthit = porthit;
		cap_ideout = ideout;
		cap_wr_n = ide_wr_n;
		cap_sp_we = sp_we;   // pulses only in this cycle
		cap_sf_we = sf_we;
		idle(2);             // registers load on the first of these
		iorq_n = 1'b1;
		wr_n = 1'b1;
		idle(2);
	endtask

	task automatic io_read(input zaddr_t addr);
		a = addr;
		iorq_n = 1'b0;
		rd_n = 1'b0;
		wait_strobe(1'b0);
		cap_porthit = porthit;
		cap_dataout = dataout;
		cap_dout = dout;
		cap_rd_n = ide_rd_n;
		cap_cs0_n = ide_cs0_n;
		cap_cs1_n = ide_cs1_n;
		cap_ide_a = ide_a;
		cap_idedataout = idedataout;
		idle(2);
		iorq_n = 1'b1;
		rd_n = 1'b1;
		idle(2);
	endtask

	task automatic xt_write(input xt_reg_t idx, input zbyte_t data);
		io_write(`ZP_XT_ADDR, idx);   // index first
		io_write(`ZP_XT_DATA, data);
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic test_reset_fe();
		zbyte_t v;
		check_border("border", border, '0);
		check_samples(8'h00, 8'h00, 8'h00, 8'h00);
		check_byte("vcfg", vcfg, 8'h00);
		check_byte("p7ffd", p7ffd, {3'b000, rstrom[0], 4'b0000});   // only rom bit set
		check_byte("peff7", peff7, 8'h00);
		check_bit("sp_we", sp_we, 1'b0);
		check_bit("sf_we", sf_we, 1'b0);
		v = next_byte();
		io_write({8'h00, `ZP_PORT_FE}, v);
		check_border("border", border, {v[1], 1'b0, v[2], 1'b0, v[0], 1'b0});
		check_samples({8{v[4]}}, {8{v[4]}}, {v[4], {7{v[3]}}}, {8{v[3]}});
		keys_in = 5'b01101;
		tape_read = 1'b1;
		io_read({8'h00, `ZP_PORT_FE});
		check_bit("porthit fe", cap_porthit, 1'b1);
		check_bit("dataout", cap_dataout, 1'b1);
		check_byte("dout fe", cap_dout, {1'b1, tape_read, 1'b0, keys_in});
		kj_in = 5'b10011;
		io_read({8'h00, `ZP_KJOY});
		check_byte("dout kjoy", cap_dout, {3'b000, kj_in});
		mus_in = next_byte();
		io_read({8'h00, `ZP_KMOUSE});
		check_byte("dout mouse", cap_dout, mus_in);
		io_read(16'h0077);   // nobody home
		check_bit("porthit", cap_porthit, 1'b0);
		check_bit("dataout", cap_dataout, 1'b0);
		check_byte("dout open", cap_dout, `ZP_OPEN_BUS);
	endtask

	task automatic test_sound();
		zbyte_t  v;
		zbyte_t  sd_port [4];
		sample_t exp_psd [4];
		int      k;
		sd_port[0] = `ZP_SD0;
		sd_port[1] = `ZP_SD1;
		sd_port[2] = `ZP_SD2;
		sd_port[3] = `ZP_SD3;
		v = next_byte();
		io_write({8'h00, `ZP_CVX1}, v);
		check_samples(v, v, v, v);
		v = next_byte();
		io_write({8'h00, `ZP_CVX2}, v);
		check_samples(v, v, v, v);
		for (k = 0; k < 4; k++)
			exp_psd[k] = v;
		dos = 1'b0;
		for (k = 0; k < 4; k++)
		begin
			exp_psd[k] = next_byte();   // own channel only
			io_write({8'h00, sd_port[k]}, exp_psd[k]);
			check_samples(exp_psd[0], exp_psd[1], exp_psd[2], exp_psd[3]);
		end
		dos = 1'b1;   // shadow hides soundrive
		for (k = 0; k < 4; k++)
		begin
			io_write({8'h00, sd_port[k]}, ~exp_psd[k]);
			check_bit("porthit sd", cap_porthit, 1'b0);
			check_samples(exp_psd[0], exp_psd[1], exp_psd[2], exp_psd[3]);
		end
		dos = 1'b0;
	endtask

	task automatic test_ext_regs();
		zbyte_t v;
		v = next_byte();
		xt_write(XBorder, v);
		check_border("border", border, v[`ZP_BORDER_W-1:0]);
		check_bit("sp_we", cap_sp_we, 1'b0);
		v = next_byte();
		xt_write(VConfig, v);
		check_byte("vcfg", vcfg, v);
		check_bit("sf_we", cap_sf_we, 1'b0);
		v = next_byte();
		xt_write(PalAddr, v);
		check_byte("sp_wa", sp_wa, v);
		xt_write(PalData, next_byte());
		check_bit("sp_we", cap_sp_we, 1'b1);
		check_bit("sf_we", cap_sf_we, 1'b0);
		check_bit("sp_we after", sp_we, 1'b0);
		v = next_byte();
		xt_write(SFAddr, v);
		check_byte("sf_wa", sf_wa, v);
		xt_write(SFData, next_byte());
		check_bit("sf_we", cap_sf_we, 1'b1);
		check_bit("sp_we", cap_sp_we, 1'b0);
		check_bit("sf_we after", sf_we, 1'b0);
	endtask

	task automatic test_paging();
		zbyte_t d;
		zbyte_t e;
		dos = 1'b0;
		d = next_byte() & 8'hDF;   // 48k lock bit clear
		io_write({8'h7F, `ZP_PORT_FD}, d);
		check_byte("p7ffd", p7ffd, d);
		e = next_byte() & 8'hFB;   // 1mb lock clear
		io_write({8'hEF, `ZP_PORT_F7}, e);
		check_byte("peff7", peff7, e);
		e = next_byte() | 8'h04;
		io_write({8'hEF, `ZP_PORT_F7}, e);
		check_byte("peff7 locked", peff7, e & 8'hB1);
		check_byte("p7ffd locked", p7ffd, d & 8'h1F);
		d = next_byte() | 8'h20;
		io_write({8'h7F, `ZP_PORT_FD}, d);
		check_byte("p7ffd locked", p7ffd, d & 8'h1F);
		io_write({8'h7F, `ZP_PORT_FD}, d ^ 8'h1F);   // refused now
		check_byte("p7ffd frozen", p7ffd, d & 8'h1F);
	endtask

	task automatic test_ide_read();
		ide_word_t w0;
		zbyte_t    lo;
		lo = next_byte();
		w0 = {next_byte(), lo};
		idein = w0;
		io_read({8'h00, `ZP_NIDE10});   // normal pair
		check_byte("dout #10", cap_dout, w0[7:0]);
		check_bit("ide_rd_n #10", cap_rd_n, 1'b0);
		check_bit("idedataout #10", cap_idedataout, 1'b0);
		check_bit("ide_cs0_n #10", cap_cs0_n, 1'b0);
		check_bit("ide_cs1_n #10", cap_cs1_n, 1'b1);
		check_ide_a("ide_a #10", cap_ide_a, 3'd0);   // data register
		idein = ~w0;   // high byte must come from the latch
		io_read({8'h00, `ZP_NIDE11});
		check_byte("dout #11", cap_dout, w0[15:8]);
		lo = next_byte();
		w0 = {next_byte(), lo};
		idein = w0;
		io_read({8'h00, `ZP_NIDE10});   // divide pair
		check_byte("dout #10", cap_dout, w0[7:0]);
		check_bit("ide_rd_n #10", cap_rd_n, 1'b0);
		idein = ~w0;
		io_read({8'h00, `ZP_NIDE10});
		check_byte("dout 2nd #10", cap_dout, w0[15:8]);
		check_bit("ide_rd_n 2nd #10", cap_rd_n, 1'b1);
		check_bit("idedataout 2nd #10", cap_idedataout, 1'b1);
		lo = next_byte();
		w0 = {next_byte(), lo};
		idein = w0;
		io_read({8'h00, 8'hF0});   // status, command block
		check_byte("dout #f0", cap_dout, w0[7:0]);
		check_ide_a("ide_a #f0", cap_ide_a, 3'd7);
		check_bit("ide_cs0_n #f0", cap_cs0_n, 1'b0);
		check_bit("ide_cs1_n #f0", cap_cs1_n, 1'b1);
		io_read({8'h00, `ZP_NIDE_C8});   // alternate status, control block
		check_byte("dout #c8", cap_dout, w0[7:0]);
		check_ide_a("ide_a #c8", cap_ide_a, 3'd6);
		check_bit("ide_cs0_n #c8", cap_cs0_n, 1'b1);
		check_bit("ide_cs1_n #c8", cap_cs1_n, 1'b0);
		check_bit("ide_rd_n #c8", cap_rd_n, 1'b0);
	endtask

	task automatic test_ide_write();
		zbyte_t hi;
		zbyte_t lo;
		hi = next_byte();
		lo = next_byte();
		io_write({8'h00, `ZP_NIDE11}, hi);   // normal, high first
		io_write({8'h00, `ZP_NIDE10}, lo);
		check_word("ideout", cap_ideout, {hi, lo});
		check_bit("ide_wr_n #10", cap_wr_n, 1'b0);
		lo = next_byte();
		hi = next_byte();
		io_write({8'h00, `ZP_NIDE10}, lo);   // divide, low byte parked
		check_bit("ide_wr_n 1st #10", cap_wr_n, 1'b1);
		io_write({8'h00, `ZP_NIDE10}, hi);
		check_word("ideout", cap_ideout, {hi, lo});
		check_bit("ide_wr_n 2nd #10", cap_wr_n, 1'b0);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		rst_n = 1'b0;
		a = '0;
		din = '0;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		idein = '0;
		keys_in = 5'b11111;   // no key down
		mus_in = '0;
		kj_in = '0;
		tape_read = 1'b0;
		dos = 1'b0;
		rstrom = 2'b01;
		idle(3);
		rst_n = 1'b1;
		idle(3);              // rom sync settles
		test_reset_fe();
		test_sound();
		test_ext_regs();
		test_paging();
		test_ide_read();
		test_ide_write();
		end_run();
	end

endmodule

`default_nettype wire
